//--- checkerPkg.sv
package checkerPkg;

	// ==================================================
	// parts the tester knows, value is the chipSel code
	typedef enum logic [7:0] {
		kind7400 = 8'd1, // quad nand
		kind7402 = 8'd2, // quad nor
		kind7404 = 8'd3, // hex inverter
		kind7486 = 8'd9  // quad xor
	} chipKind;

	// one pass of apply, settle, sample per vector
	typedef enum logic [2:0] {
		stIdle,
		stApply,
		stSettle,
		stSample,
		stDone
	} seqState;

	// ==================================================
	// vector i puts A = i[0] and B = i[1] on every gate
	localparam int vectorCount = 4;
	localparam int vectorIdxW = 2;
	localparam int settleCycles = 2; // clocks between apply and sample
	localparam int gateCount = 6;    // quad parts leave bits 5:4 at zero

endpackage

//--- boardPkg.sv
package boardPkg;

	// ==================================================
	// socket side
	localparam int pinCount = 16; // pins 1..16, bit 0 unused

	// ==================================================
	// display side
	localparam int segW = 7;   // g f e d c b a, active low
	localparam int digitW = 4;

	// result digit on hex2
	localparam logic [digitW-1:0] digitPass = 4'hA;
	localparam logic [digitW-1:0] digitFail = 4'hF;

endpackage

//--- checkSequencer.sv
`timescale 1ns/1ps

module checkSequencer (
	input  logic Clk,
	input  logic rstN,
	input  logic run,
	input  checkerPkg::chipKind chipSel,
	input  logic [checkerPkg::gateCount-1:0] observed,
	input  logic [checkerPkg::gateCount-1:0] expected,
	input  logic supported,
	output checkerPkg::chipKind kind,
	output logic [checkerPkg::vectorIdxW-1:0] vectorIdx,
	output logic drive,
	output logic busy,
	output logic done,
	output logic pass
);

	checkerPkg::seqState state;
	logic [$clog2(checkerPkg::settleCycles+1)-1:0] settleCnt;
	logic mismatch; // sticky over the whole test
	logic vecMiss;
	logic lastVector;
	logic startTest;
	logic settled;

	assign vecMiss = (observed != expected);
	assign lastVector = (int'(vectorIdx) == checkerPkg::vectorCount - 1);
	assign settled = (int'(settleCnt) == checkerPkg::settleCycles - 1);

	// run only counts when no test is in flight
	assign startTest = run && (state == checkerPkg::stIdle || state == checkerPkg::stDone);

	// socket is driven for the whole vector, sample included
	assign drive = (state == checkerPkg::stApply)
		|| (state == checkerPkg::stSettle)
		|| (state == checkerPkg::stSample);

	// part code held for the length of the test
	always_ff @(posedge Clk)
	begin
		if (startTest)
			kind <= chipSel;
	end

	// ==================================================
	// test FSM
	always_ff @(posedge Clk)
	begin
		if (!rstN)
		begin
			state <= checkerPkg::stIdle;
			vectorIdx <= '0;
			settleCnt <= '0;
			mismatch <= 1'b0;
			busy <= 1'b0;
			done <= 1'b0;
			pass <= 1'b0;
		end
		else
		begin
			case (state)
				checkerPkg::stIdle, checkerPkg::stDone:
				begin
					if (startTest)
					begin
						state <= checkerPkg::stApply;
						vectorIdx <= '0;
						mismatch <= 1'b0;
						busy <= 1'b1;
						done <= 1'b0;
						pass <= 1'b0;
					end
				end
				checkerPkg::stApply:
				begin
					if (!supported) // unknown part, no vectors at all
					begin
						state <= checkerPkg::stDone;
						busy <= 1'b0;
						done <= 1'b1;
					end
					else
					begin
						state <= checkerPkg::stSettle;
						settleCnt <= '0;
					end
				end
				checkerPkg::stSettle:
				begin
					if (settled)
						state <= checkerPkg::stSample;
					else
						settleCnt <= settleCnt + 1'b1;
				end
				checkerPkg::stSample:
				begin
					mismatch <= mismatch | vecMiss;
					if (lastVector)
					begin
						state <= checkerPkg::stDone;
						busy <= 1'b0;
						done <= 1'b1;
						pass <= supported && !(mismatch || vecMiss); // this vector counts too
					end
					else
					begin
						state <= checkerPkg::stApply;
						vectorIdx <= vectorIdx + 1'b1;
					end
				end
				default:
				begin
					state <= checkerPkg::stIdle;
					busy <= 1'b0;
				end
			endcase
		end
	end

endmodule

//--- chipAdapter.sv
`timescale 1ns/1ps

module chipAdapter (
	input  checkerPkg::chipKind kind,
	input  logic [checkerPkg::vectorIdxW-1:0] vectorIdx,
	input  logic drive,
	input  logic [boardPkg::pinCount:0] pinIn,
	output logic [boardPkg::pinCount:0] pinOut,
	output logic [boardPkg::pinCount:0] pinOe,
	output logic [checkerPkg::gateCount-1:0] observed,
	output logic [checkerPkg::gateCount-1:0] expected,
	output logic supported
);

	logic a;
	logic b;
	logic [boardPkg::pinCount:0] inMask; // input pins of the part
	logic gateNand;
	logic gateNor;
	logic gateXor;
	logic gateNot;

	assign a = vectorIdx[0];
	assign b = vectorIdx[1];

	assign gateNand = ~(a & b);
	assign gateNor = ~(a | b);
	assign gateXor = a ^ b;
	assign gateNot = ~a;

	// never drive a part output, and nothing at all between tests
	assign pinOe = drive ? inMask : '0;

	// ==================================================
	// pin placement per part
	always_comb
	begin
		pinOut = '0;
		inMask = '0;
		observed = '0;
		expected = '0;
		supported = 1'b1;
		case (kind)
			checkerPkg::kind7400, checkerPkg::kind7486:
			begin
				pinOut[1] = a;
				pinOut[2] = b;
				pinOut[4] = a;
				pinOut[5] = b;
				pinOut[10] = a;
				pinOut[9] = b;
				pinOut[13] = a;
				pinOut[12] = b;
				inMask = 17'h03636; // 1 2 4 5 9 10 12 13
				observed[3:0] = {pinIn[11], pinIn[8], pinIn[6], pinIn[3]};
				expected[3:0] = {4{(kind == checkerPkg::kind7400) ? gateNand : gateXor}};
			end
			checkerPkg::kind7402:
			begin
				// nor pinout has outputs first
				pinOut[2] = a;
				pinOut[3] = b;
				pinOut[5] = a;
				pinOut[6] = b;
				pinOut[8] = a;
				pinOut[9] = b;
				pinOut[11] = a;
				pinOut[12] = b;
				inMask = 17'h01b6c; // 2 3 5 6 8 9 11 12
				observed[3:0] = {pinIn[13], pinIn[10], pinIn[4], pinIn[1]};
				expected[3:0] = {4{gateNor}};
			end
			checkerPkg::kind7404:
			begin
				pinOut[1] = a;
				pinOut[3] = a;
				pinOut[5] = a;
				pinOut[9] = a;
				pinOut[11] = a;
				pinOut[13] = a;
				inMask = 17'h02a2a; // odd pins except 7
				observed = {pinIn[12], pinIn[10], pinIn[8], pinIn[6], pinIn[4], pinIn[2]};
				expected = {checkerPkg::gateCount{gateNot}};
			end
			default:
				supported = 1'b0; // socket stays floating
		endcase
	end

endmodule

//--- segDecoder.sv
`timescale 1ns/1ps

module segDecoder (
	input  logic [boardPkg::digitW-1:0] digit,
	output logic [boardPkg::segW-1:0] seg
);

	// segment order g f e d c b a, a lit segment is 0
	always_comb
	begin
		case (digit)
			4'h0: seg = 7'b1000000;
			4'h1: seg = 7'b1111001;
			4'h2: seg = 7'b0100100;
			4'h3: seg = 7'b0110000;
			4'h4: seg = 7'b0011001;
			4'h5: seg = 7'b0010010;
			4'h6: seg = 7'b0000010;
			4'h7: seg = 7'b1111000;
			4'h8: seg = 7'b0000000;
			4'h9: seg = 7'b0010000;
			4'hA: seg = 7'b0001000; // pass
			4'hB: seg = 7'b0000011; // lower case b
			4'hC: seg = 7'b1000110;
			4'hD: seg = 7'b0100001; // lower case d
			4'hE: seg = 7'b0000110;
			4'hF: seg = 7'b0001110; // fail
			default: seg = 7'b1111111;
		endcase
	end

endmodule

//--- chipChecker.sv
`timescale 1ns/1ps

module chipChecker (
	input  logic Clk,
	input  logic rstN,
	input  logic run,
	input  logic [7:0] chipSel,
	output logic [boardPkg::pinCount:0] pinOut,
	output logic [boardPkg::pinCount:0] pinOe,
	input  logic [boardPkg::pinCount:0] pinIn,
	output logic busy,
	output logic done,
	output logic pass,
	output logic [boardPkg::segW-1:0] hex0,
	output logic [boardPkg::segW-1:0] hex1,
	output logic [boardPkg::segW-1:0] hex2
);

	checkerPkg::chipKind selKind;
	checkerPkg::chipKind kind; // latched copy
	logic [checkerPkg::vectorIdxW-1:0] vectorIdx;
	logic drive;
	logic supported;
	logic [checkerPkg::gateCount-1:0] observed;
	logic [checkerPkg::gateCount-1:0] expected;
	logic [boardPkg::digitW-1:0] resultDigit;

	assign selKind = checkerPkg::chipKind'(chipSel);

	// blank zero until a verdict exists
	assign resultDigit = done ? (pass ? boardPkg::digitPass : boardPkg::digitFail) : '0;

	// ==================================================
	checkSequencer sequencer (
		.Clk(Clk),
		.rstN(rstN),
		.run(run),
		.chipSel(selKind),
		.observed(observed),
		.expected(expected),
		.supported(supported),
		.kind(kind),
		.vectorIdx(vectorIdx),
		.drive(drive),
		.busy(busy),
		.done(done),
		.pass(pass)
	);

	chipAdapter adapter (
		.kind(kind),
		.vectorIdx(vectorIdx),
		.drive(drive),
		.pinIn(pinIn),
		.pinOut(pinOut),
		.pinOe(pinOe),
		.observed(observed),
		.expected(expected),
		.supported(supported)
	);

	// ==================================================
	// displays, code digits follow chipSel live
	segDecoder dispLow (.digit(chipSel[3:0]), .seg(hex0));
	segDecoder dispHigh (.digit(chipSel[7:4]), .seg(hex1));
	segDecoder dispResult (.digit(resultDigit), .seg(hex2));

endmodule

//--- chipCheckerTasks.svh
// ==================================================
// compare tasks
task automatic checkBit(input string test, input logic exp, input logic act);
	if (act !== exp)
	begin
		$display("FAIL %s: expected %b, actual %b", test, exp, act);
		errors++;
	end
endtask

task automatic checkSeg(input string test, input logic [boardPkg::segW-1:0] exp,
		input logic [boardPkg::segW-1:0] act);
	if (act !== exp)
	begin
		$display("FAIL %s: expected %b, actual %b", test, exp, act);
		errors++;
	end
endtask

task automatic checkKind(input string test, input checkerPkg::chipKind exp,
		input checkerPkg::chipKind act);
	if (act !== exp)
	begin
		$display("FAIL %s: expected %0d, actual %0d", test, exp, act);
		errors++;
	end
endtask

// standard hex display, g..a, lit segment low
function automatic logic [boardPkg::segW-1:0] segFor(input logic [boardPkg::digitW-1:0] d);
	logic [boardPkg::segW-1:0] pat [16];
	pat = '{7'h40, 7'h79, 7'h24, 7'h30,
		7'h19, 7'h12, 7'h02, 7'h78,
		7'h00, 7'h10, 7'h08, 7'h03,
		7'h46, 7'h21, 7'h06, 7'h0e};
	return pat[d];
endfunction

function automatic logic isPart(input logic [7:0] code);
	return code == 8'd1 || code == 8'd2 || code == 8'd3 || code == 8'd9;
endfunction

// ==================================================
// run handshake
task automatic startRun(input string test, input logic [7:0] code);
	chipSel = code;
	run = 1'b1;
	@(negedge Clk);
	run = 1'b0;
	checkBit({test, " busy"}, 1'b1, busy);
	checkBit({test, " done cleared"}, 1'b0, done);
endtask

task automatic waitDone(input string test);
	int waited;
	waited = 0;
	while (!done && waited < 40)
	begin
		@(negedge Clk);
		waited++;
	end
	if (!done)
	begin
		$display("%s: done never came up after run", test);
		errors++;
	end
	else if (pinOe != '0)
	begin
		$display("%s: socket still driven after done", test);
		errors++;
	end
endtask

task automatic runTest(input string test, input logic [7:0] code,
		input checkerPkg::chipKind part, input logic [4:0] stuck);
	logic expPass;
	expPass = isPart(code) && stuck == 5'd0;
	sockKind = part;
	stuckPin = stuck;
	startRun(test, code);
	waitDone(test);
	checkBit({test, " pass"}, expPass, pass);
	checkSeg({test, " hex2"},
		segFor(expPass ? boardPkg::digitPass : boardPkg::digitFail), hex2);
	checkSeg({test, " hex0"}, segFor(code[3:0]), hex0);
	checkSeg({test, " hex1"}, segFor(code[7:4]), hex1);
endtask

// ==================================================
// directed tests
task automatic checkReset();
	checkBit("reset busy", 1'b0, busy);
	checkBit("reset done", 1'b0, done);
	checkBit("reset pass", 1'b0, pass);
	checkSeg("reset hex2", segFor(4'h0), hex2);
	if (pinOe != '0)
	begin
		$display("reset: socket driven out of reset, pinOe=%h", pinOe);
		errors++;
	end
endtask

task automatic goodParts();
	runTest("good 7400", 8'd1, checkerPkg::kind7400, 5'd0);
	runTest("good 7402", 8'd2, checkerPkg::kind7402, 5'd0);
	runTest("good 7404", 8'd3, checkerPkg::kind7404, 5'd0);
	runTest("good 7486", 8'd9, checkerPkg::kind7486, 5'd0);
endtask

task automatic faultyParts();
	runTest("stuck 7400", 8'd1, checkerPkg::kind7400, 5'd6);
	runTest("stuck 7402", 8'd2, checkerPkg::kind7402, 5'd10);
	runTest("stuck 7404", 8'd3, checkerPkg::kind7404, 5'd12);
	runTest("stuck 7486", 8'd9, checkerPkg::kind7486, 5'd3);
endtask

task automatic unknownCodes();
	logic [7:0] code;
	noDrive = 1'b1;
	runTest("code 00", 8'h00, checkerPkg::kind7400, 5'd0);
	runTest("code 04", 8'h04, checkerPkg::kind7400, 5'd0);
	runTest("code ff", 8'hff, checkerPkg::kind7400, 5'd0);
	for (int i = 0; i < 3; i++)
	begin
		code = 8'($random(seed));
		while (isPart(code))
			code = 8'($random(seed)); // members are covered above
		runTest("random code", code, checkerPkg::kind7400, 5'd0);
	end
	noDrive = 1'b0;
endtask

task automatic selChangeWhileBusy();
	sockKind = checkerPkg::kind7404;
	stuckPin = 5'd0;
	startRun("busy change", 8'd3);
	repeat (3) @(negedge Clk);
	chipSel = 8'd9;
	run = 1'b1; // should be ignored
	@(negedge Clk);
	run = 1'b0;
	checkKind("busy change kind", checkerPkg::kind7404, uut.kind);
	checkSeg("busy change hex0", segFor(4'h9), hex0);
	waitDone("busy change");
	checkBit("busy change pass", 1'b1, pass);
	checkKind("busy change kind at done", checkerPkg::kind7404, uut.kind);
endtask

//--- chipCheckerTb.sv
`timescale 1ns/1ps

module chipCheckerTb;

	localparam int testCount = 15;
	localparam int watchdogCycles = testCount * (16 + 10) + 20;

	logic Clk;
	logic rstN;
	logic run;
	logic [7:0] chipSel;
	logic [boardPkg::pinCount:0] pinOut;
	logic [boardPkg::pinCount:0] pinOe;
	logic [boardPkg::pinCount:0] pinIn;
	logic busy;
	logic done;
	logic pass;
	logic [boardPkg::segW-1:0] hex0;
	logic [boardPkg::segW-1:0] hex1;
	logic [boardPkg::segW-1:0] hex2;

	checkerPkg::chipKind sockKind; // part sitting in the socket
	checkerPkg::seqState seqNow;
	logic [4:0] stuckPin; // output held at 0, zero for a good part
	logic noDrive;        // high while an unknown code runs
	logic [boardPkg::pinCount:0] pinLevel; // level the part sees on each pin
	int errors;
	integer seed;

	assign seqNow = uut.sequencer.state;

	// open ttl inputs read high
	assign pinLevel = (pinOut & pinOe) | ~pinOe;

	chipChecker uut (.*);

	initial
	begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;
	end

	// ==================================================
	// socket model
	function automatic logic twoIn(input checkerPkg::chipKind k, input logic x, input logic y);
		return (k == checkerPkg::kind7486) ? (x ^ y) : ~(x & y);
	endfunction

	// output pins from the datasheet pinouts
	function automatic logic [boardPkg::pinCount:0] outputPins(input checkerPkg::chipKind k);
		case (k)
			checkerPkg::kind7402: return 17'h02412; // 1 4 10 13
			checkerPkg::kind7404: return 17'h01554; // 2 4 6 8 10 12
			default: return 17'h00948;              // 3 6 8 11
		endcase
	endfunction

	always_comb
	begin
		pinIn = '0;
		case (sockKind)
			checkerPkg::kind7402:
			begin
				pinIn[1] = ~(pinLevel[2] | pinLevel[3]);
				pinIn[4] = ~(pinLevel[5] | pinLevel[6]);
				pinIn[10] = ~(pinLevel[8] | pinLevel[9]);
				pinIn[13] = ~(pinLevel[11] | pinLevel[12]);
			end
			checkerPkg::kind7404:
			begin
				pinIn[2] = ~pinLevel[1];
				pinIn[4] = ~pinLevel[3];
				pinIn[6] = ~pinLevel[5];
				pinIn[8] = ~pinLevel[9];
				pinIn[10] = ~pinLevel[11];
				pinIn[12] = ~pinLevel[13];
			end
			default:
			begin
				pinIn[3] = twoIn(sockKind, pinLevel[1], pinLevel[2]);
				pinIn[6] = twoIn(sockKind, pinLevel[4], pinLevel[5]);
				pinIn[8] = twoIn(sockKind, pinLevel[9], pinLevel[10]);
				pinIn[11] = twoIn(sockKind, pinLevel[12], pinLevel[13]);
			end
		endcase
		if (stuckPin != 5'd0)
			pinIn[stuckPin] = 1'b0; // faulty gate
	end

	// pin drive watch, every cycle
	always @(negedge Clk)
	begin
		if (rstN && (pinOe & outputPins(sockKind)) != '0)
		begin
			$display("driver contention on %s outputs in state %s, pinOe=%h",
				sockKind.name(), seqNow.name(), pinOe);
			errors++;
		end
		if (noDrive && pinOe != '0)
		begin
			$display("socket driven for an unknown code, pinOe=%h", pinOe);
			errors++;
		end
	end

	`include "chipCheckerTasks.svh"

	initial
	begin
		repeat (watchdogCycles) @(posedge Clk);
		$display("timeout: tests still running after %0d cycles", watchdogCycles);
		$display("Something failed");
		$finish;
	end

	// ==================================================
	initial
	begin
		seed = 32'hc6c6_1b6d;
		errors = 0;
		rstN = 1'b0;
		run = 1'b0;
		chipSel = 8'h00;
		sockKind = checkerPkg::kind7400;
		stuckPin = 5'd0;
		noDrive = 1'b0;
		repeat (8) @(negedge Clk);
		rstN = 1'b1;
		checkReset();
		goodParts();
		faultyParts();
		unknownCodes();
		selChangeWhileBusy();
		$display("checks finished with %0d errors", errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- filelist.f
+incdir+.
checkerPkg.sv
boardPkg.sv
checkSequencer.sv
chipAdapter.sv
segDecoder.sv
chipChecker.sv
chipCheckerTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the chip checker testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --timescale 1ns/1ps -f filelist.f \
	--top-module chipCheckerTb -o simChipChecker
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

./obj_dir/simChipChecker > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if grep -q "^Everything OK$" sim.log; then
	exit 0
fi
exit 1
